// File: include/dev_bridge_settings.svh
`ifndef DEV_BRIDGE_SETTINGS_SVH
`define DEV_BRIDGE_SETTINGS_SVH

// ---------------------------------------------------------------------
// bus widths
// ---------------------------------------------------------------------
`define DEV_XLEN        32              // address and data word
`define DEV_BE_W        (`DEV_XLEN/8)   // one enable per byte

// ---------------------------------------------------------------------
// device map, decoded on the top address byte
// ---------------------------------------------------------------------
`define DEV_SEL_HI_W    8
`define DEV_UART_BASE   8'hC0           // serial port window
`define DEV_SPI_BASE    8'hC2           // storage controller over axi-lite

// extra cycles the core stays in reset after rst drops
`define DEV_RST_HOLD    8

`endif

// File: rtl/dev_bus_pkg.sv
`include "dev_bridge_settings.svh"

// core-side device bus types
package dev_bus_pkg;

    // ---------------------------------------------------------------------
    // payload words
    // ---------------------------------------------------------------------
    typedef logic [`DEV_XLEN-1:0] dev_addr_t;   // byte address
    typedef logic [`DEV_XLEN-1:0] dev_data_t;   // one bus word
    typedef logic [`DEV_BE_W-1:0] dev_be_t;     // byte lanes

    // ---------------------------------------------------------------------
    // where an access completes
    // ---------------------------------------------------------------------
    typedef enum logic [1:0]
    {
        TGT_NONE = 2'd0,    // unmapped, answered by the decoder itself
        TGT_UART = 2'd1,    // memory-mapped serial port
        TGT_AXI  = 2'd2     // axi-lite master
    } dev_target_e;

    // 2'd3 unused, decodes as no target

endpackage

// File: rtl/axi_lite_pkg.sv
// axi4-lite protocol types

package axi_lite_pkg;

    // ---------------------------------------------------------------------
    // response codes on bresp / rresp
    // ---------------------------------------------------------------------
    typedef enum logic [1:0]
    {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,     // not expected from a lite slave
        SLVERR = 2'b10,     // slave reported an error
        DECERR = 2'b11      // no slave at that address
    } axi_resp_e;

    // msb set means failure for both error codes

    // ---------------------------------------------------------------------
    // master channel sequencing
    // ---------------------------------------------------------------------
    typedef enum logic [1:0]
    {
        AX_IDLE = 2'd0,     // waiting for a routed request
        AX_ADDR = 2'd1,     // address / write data valids up
        AX_RESP = 2'd2,     // waiting for b or r
        AX_DONE = 2'd3      // done pulse back to the decoder
    } axi_state_e;

endpackage

// File: rtl/dev_req_if.sv
// one routed device access, decoder to axi master

interface dev_req_if;
    import dev_bus_pkg::*;

    // request, a one-cycle pulse with fields held stable
    logic      req;
    dev_addr_t addr;
    logic      we;      // 1 = write
    dev_be_t   be;
    dev_data_t wdata;

    // completion
    dev_data_t rdata;   // zero for writes
    logic      done;    // one-cycle pulse, ends the access
    logic      err;     // response msb

    modport initiator
    (
        output req, addr, we, be, wdata,
        input  rdata, done, err
    );

    modport target
    (
        input  req, addr, we, be, wdata,
        output rdata, done, err
    );

endinterface

// File: rtl/rst_stretch.sv
`include "dev_bridge_settings.svh"

module rst_stretch
(
    input  logic clk,
    input  logic rst,
    output logic core_rst_o
);

    localparam int CNT_W = $clog2(`DEV_RST_HOLD + 1);

    logic [CNT_W-1:0] hold_cnt;     // cycles left after rst drops

    // load while rst is up, then count down to zero and stop
    always_ff @(posedge clk)
    begin
        if (rst)
            hold_cnt <= CNT_W'(`DEV_RST_HOLD);
        else if (hold_cnt != '0)
            hold_cnt <= hold_cnt - 1'b1;
    end

    // rst term covers the cycles before the first load
    assign core_rst_o = rst | (hold_cnt != '0);

endmodule

// File: rtl/dev_decoder.sv
`include "dev_bridge_settings.svh"

module dev_decoder
(
    input  logic                   clk,
    input  logic                   core_rst_i,
    // core device bus
    input  logic                   dev_strobe_i,
    input  logic                   dev_we_i,
    input  dev_bus_pkg::dev_addr_t dev_addr_i,
    input  dev_bus_pkg::dev_be_t   dev_be_i,
    input  dev_bus_pkg::dev_data_t dev_wdata_i,
    output dev_bus_pkg::dev_data_t dev_rdata_o,
    output logic                   dev_ready_o,
    output logic                   dev_err_o,
    // serial port target
    output logic                   uart_en_o,
    output logic                   uart_we_o,
    output logic [1:0]             uart_addr_o,
    output dev_bus_pkg::dev_be_t   uart_be_o,
    output dev_bus_pkg::dev_data_t uart_wdata_o,
    input  dev_bus_pkg::dev_data_t uart_rdata_i,
    input  logic                   uart_ready_i,
    // axi side
    dev_req_if.initiator           axi_req
);
    import dev_bus_pkg::*;

    dev_target_e sel_tgt;       // decode of the incoming address
    dev_target_e cur_tgt;       // target of the access in flight
    logic        accept;
    logic        uart_done;
    logic        axi_done;
    dev_addr_t   acc_addr;
    logic        acc_we;
    dev_be_t     acc_be;
    dev_data_t   acc_wdata;

    // ---------------------------------------------------------------------
    // address decode, top byte only
    // ---------------------------------------------------------------------
    always_comb
    begin
        case (dev_addr_i[`DEV_XLEN-1 -: `DEV_SEL_HI_W])
            `DEV_UART_BASE: sel_tgt = TGT_UART;
            `DEV_SPI_BASE:  sel_tgt = TGT_AXI;
            default:        sel_tgt = TGT_NONE;
        endcase
    end

    assign accept    = dev_strobe_i && (cur_tgt == TGT_NONE);  // one access at a time
    assign uart_done = uart_ready_i && (cur_tgt == TGT_UART);
    assign axi_done  = axi_req.done && (cur_tgt == TGT_AXI);

    // issue pulses, completion pulse, target tracking
    always_ff @(posedge clk)
    begin
        if (core_rst_i)
        begin
            cur_tgt     <= TGT_NONE;
            uart_en_o   <= 1'b0;
            axi_req.req <= 1'b0;
            dev_ready_o <= 1'b0;
        end
        else
        begin
            uart_en_o   <= accept && (sel_tgt == TGT_UART);
            axi_req.req <= accept && (sel_tgt == TGT_AXI);
            // unmapped completes straight away
            dev_ready_o <= (accept && (sel_tgt == TGT_NONE)) || uart_done || axi_done;
            if (accept)
                cur_tgt <= sel_tgt;     // stays none for unmapped
            else if (uart_done || axi_done)
                cur_tgt <= TGT_NONE;
        end
    end

    // ---------------------------------------------------------------------
    // payload capture and return steering
    // ---------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            acc_addr  <= dev_addr_i;
            acc_we    <= dev_we_i;
            acc_be    <= dev_be_i;
            acc_wdata <= dev_wdata_i;
        end
        if (accept && (sel_tgt == TGT_NONE))
        begin
            dev_rdata_o <= '0;
            dev_err_o   <= 1'b1;
        end
        else if (uart_done)
        begin
            dev_rdata_o <= uart_rdata_i;
            dev_err_o   <= 1'b0;            // serial port has no error path
        end
        else if (axi_done)
        begin
            dev_rdata_o <= axi_req.rdata;
            dev_err_o   <= axi_req.err;
        end
    end

    // both targets see the same registered fields
    assign uart_we_o     = acc_we;
    assign uart_addr_o   = acc_addr[3:2];   // word select within the port
    assign uart_be_o     = acc_be;
    assign uart_wdata_o  = acc_wdata;
    assign axi_req.addr  = acc_addr;
    assign axi_req.we    = acc_we;
    assign axi_req.be    = acc_be;
    assign axi_req.wdata = acc_wdata;

endmodule

// File: rtl/axi_lite_master.sv
`include "dev_bridge_settings.svh"

module axi_lite_master
(
    input  logic                    clk,
    input  logic                    core_rst_i,
    // routed access from the decoder
    dev_req_if.target               axi_req,
    // write address / data
    output dev_bus_pkg::dev_addr_t  awaddr_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,
    output dev_bus_pkg::dev_data_t  wdata_o,
    output dev_bus_pkg::dev_be_t    wstrb_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,
    // write response
    input  axi_lite_pkg::axi_resp_e bresp_i,
    input  logic                    bvalid_i,
    output logic                    bready_o,
    // read
    output dev_bus_pkg::dev_addr_t  araddr_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,
    input  dev_bus_pkg::dev_data_t  rdata_i,
    input  axi_lite_pkg::axi_resp_e rresp_i,
    input  logic                    rvalid_i,
    output logic                    rready_o
);
    import dev_bus_pkg::*;
    import axi_lite_pkg::*;

    axi_state_e state;
    logic       is_write;       // latched direction
    dev_addr_t  ax_addr;
    dev_data_t  ax_wdata;
    dev_be_t    ax_strb;
    dev_data_t  rsp_data;
    logic       rsp_err;
    logic       addr_pend;      // a valid still waiting for its ready
    logic       b_hs;
    logic       r_hs;

    assign addr_pend = (awvalid_o && !awready_i) || (wvalid_o && !wready_i)
                     || (arvalid_o && !arready_i);
    assign b_hs = bvalid_i && bready_o;
    assign r_hs = rvalid_i && rready_o;

    // ---------------------------------------------------------------------
    // channel sequencing
    // ---------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (core_rst_i)
        begin
            state     <= AX_IDLE;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            arvalid_o <= 1'b0;
            bready_o  <= 1'b0;
            rready_o  <= 1'b0;
        end
        else
        begin
            case (state)
                AX_IDLE:
                    if (axi_req.req)
                    begin
                        awvalid_o <= axi_req.we;    // aw and w raised together
                        wvalid_o  <= axi_req.we;
                        arvalid_o <= !axi_req.we;
                        state     <= AX_ADDR;
                    end
                AX_ADDR:
                begin
                    // each valid drops on its own handshake
                    if (awready_i)
                        awvalid_o <= 1'b0;
                    if (wready_i)
                        wvalid_o <= 1'b0;
                    if (arready_i)
                        arvalid_o <= 1'b0;
                    if (!addr_pend)
                        state <= AX_RESP;
                end
                AX_RESP:
                begin
                    // ready one cycle after valid, up for a single cycle
                    if (is_write)
                        bready_o <= bvalid_i && !bready_o;
                    else
                        rready_o <= rvalid_i && !rready_o;
                    if (b_hs || r_hs)
                        state <= AX_DONE;
                end
                default:
                    state <= AX_IDLE;   // AX_DONE, done pulse is out
            endcase
        end
    end

    // ---------------------------------------------------------------------
    // request and response payload
    // ---------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if ((state == AX_IDLE) && axi_req.req)
        begin
            is_write <= axi_req.we;
            ax_addr  <= axi_req.addr;
            ax_wdata <= axi_req.wdata;
            ax_strb  <= axi_req.be;
        end
        if (b_hs)
        begin
            rsp_data <= '0;
            rsp_err  <= bresp_i[1];
        end
        else if (r_hs)
        begin
            rsp_data <= rdata_i;
            rsp_err  <= rresp_i[1];     // slverr or decerr
        end
    end

    assign awaddr_o = ax_addr;
    assign araddr_o = ax_addr;
    assign wdata_o  = ax_wdata;
    assign wstrb_o  = ax_strb;

    assign axi_req.rdata = rsp_data;
    assign axi_req.err   = rsp_err;
    assign axi_req.done  = (state == AX_DONE);  // one cycle after the response handshake

endmodule

// File: rtl/dev_bridge_top.sv
module dev_bridge_top
(
    input  logic                    clk,
    input  logic                    rst,
    // core device bus
    input  logic                    dev_strobe_i,
    input  dev_bus_pkg::dev_addr_t  dev_addr_i,
    input  logic                    dev_we_i,
    input  dev_bus_pkg::dev_be_t    dev_be_i,
    input  dev_bus_pkg::dev_data_t  dev_wdata_i,
    output dev_bus_pkg::dev_data_t  dev_rdata_o,
    output logic                    dev_ready_o,
    output logic                    dev_err_o,
    // serial port
    output logic                    uart_en_o,
    output logic [1:0]              uart_addr_o,
    output logic                    uart_we_o,
    output dev_bus_pkg::dev_be_t    uart_be_o,
    output dev_bus_pkg::dev_data_t  uart_wdata_o,
    input  dev_bus_pkg::dev_data_t  uart_rdata_i,
    input  logic                    uart_ready_i,
    // axi-lite to the storage controller
    output dev_bus_pkg::dev_addr_t  awaddr_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,
    output dev_bus_pkg::dev_data_t  wdata_o,
    output dev_bus_pkg::dev_be_t    wstrb_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,
    input  axi_lite_pkg::axi_resp_e bresp_i,
    input  logic                    bvalid_i,
    output logic                    bready_o,
    output dev_bus_pkg::dev_addr_t  araddr_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,
    input  dev_bus_pkg::dev_data_t  rdata_i,
    input  axi_lite_pkg::axi_resp_e rresp_i,
    input  logic                    rvalid_i,
    output logic                    rready_o
);

    logic core_rst;     // stretched reset for the whole bridge

    dev_req_if axi_req ();

    // ---------------------------------------------------------------------
    rst_stretch u_rst_stretch
    (
        .clk        (clk),
        .rst        (rst),
        .core_rst_o (core_rst)
    );

    dev_decoder u_dev_decoder
    (
        .clk          (clk),
        .core_rst_i   (core_rst),
        .dev_strobe_i (dev_strobe_i),
        .dev_we_i     (dev_we_i),
        .dev_addr_i   (dev_addr_i),
        .dev_be_i     (dev_be_i),
        .dev_wdata_i  (dev_wdata_i),
        .dev_rdata_o  (dev_rdata_o),
        .dev_ready_o  (dev_ready_o),
        .dev_err_o    (dev_err_o),
        .uart_en_o    (uart_en_o),
        .uart_we_o    (uart_we_o),
        .uart_addr_o  (uart_addr_o),
        .uart_be_o    (uart_be_o),
        .uart_wdata_o (uart_wdata_o),
        .uart_rdata_i (uart_rdata_i),
        .uart_ready_i (uart_ready_i),
        .axi_req      (axi_req.initiator)
    );

    axi_lite_master u_axi_lite_master
    (
        .clk        (clk),
        .core_rst_i (core_rst),
        .axi_req    (axi_req.target),
        .awaddr_o   (awaddr_o),
        .awvalid_o  (awvalid_o),
        .awready_i  (awready_i),
        .wdata_o    (wdata_o),
        .wstrb_o    (wstrb_o),
        .wvalid_o   (wvalid_o),
        .wready_i   (wready_i),
        .bresp_i    (bresp_i),
        .bvalid_i   (bvalid_i),
        .bready_o   (bready_o),
        .araddr_o   (araddr_o),
        .arvalid_o  (arvalid_o),
        .arready_i  (arready_i),
        .rdata_i    (rdata_i),
        .rresp_i    (rresp_i),
        .rvalid_i   (rvalid_i),
        .rready_o   (rready_o)
    );

endmodule

// File: verification/dev_bridge_checker.sv
`include "dev_bridge_settings.svh"

module dev_bridge_checker
(
    input  logic                   clk,
    input  logic                   core_rst_i,
    input  logic                   dev_strobe_i,
    input  dev_bus_pkg::dev_addr_t dev_addr_i,
    input  logic                   dev_ready_i,
    input  logic                   uart_en_i,
    input  logic                   awvalid_i,
    input  logic                   awready_i,
    input  logic                   wvalid_i,
    input  logic                   wready_i,
    input  logic                   arvalid_i,
    input  logic                   arready_i,
    input  logic                   bready_i,
    input  logic                   rready_i
);
    import dev_bus_pkg::*;

    int          err_cnt = 0;   // read back by the testbench at the end
    dev_target_e strobe_tgt;    // where the address on the bus would go
    logic        any_out;

    always_comb
    begin
        if (dev_addr_i[`DEV_XLEN-1 -: `DEV_SEL_HI_W] == `DEV_UART_BASE)
            strobe_tgt = TGT_UART;
        else if (dev_addr_i[`DEV_XLEN-1 -: `DEV_SEL_HI_W] == `DEV_SPI_BASE)
            strobe_tgt = TGT_AXI;
        else
            strobe_tgt = TGT_NONE;
    end

    assign any_out = dev_ready_i | uart_en_i | awvalid_i | wvalid_i | arvalid_i
                   | bready_i | rready_i;

    // ------------------------------------------------------------------
    // reset window, registers settle after the first reset edge
    reset_quiet: assert property (@(posedge clk)
        core_rst_i && $past(core_rst_i) |-> !any_out)
        else begin $error("output active during internal reset"); err_cnt++; end

    // valids hold until their ready
    aw_hold: assert property (@(posedge clk) disable iff (core_rst_i)
        awvalid_i && !awready_i |=> awvalid_i)
        else begin $error("awvalid dropped before awready"); err_cnt++; end
    w_hold: assert property (@(posedge clk) disable iff (core_rst_i)
        wvalid_i && !wready_i |=> wvalid_i)
        else begin $error("wvalid dropped before wready"); err_cnt++; end
    ar_hold: assert property (@(posedge clk) disable iff (core_rst_i)
        arvalid_i && !arready_i |=> arvalid_i)
        else begin $error("arvalid dropped before arready"); err_cnt++; end

    // ------------------------------------------------------------------
    // single-cycle pulses
    b_pulse: assert property (@(posedge clk) disable iff (core_rst_i)
        bready_i |=> !bready_i)
        else begin $error("bready longer than one cycle"); err_cnt++; end
    r_pulse: assert property (@(posedge clk) disable iff (core_rst_i)
        rready_i |=> !rready_i)
        else begin $error("rready longer than one cycle"); err_cnt++; end
    ready_pulse: assert property (@(posedge clk) disable iff (core_rst_i)
        dev_ready_i |=> !dev_ready_i)
        else begin $error("dev_ready longer than one cycle"); err_cnt++; end

    // serial port enable follows a strobe into its window
    uart_window: assert property (@(posedge clk) disable iff (core_rst_i)
        uart_en_i |-> $past(dev_strobe_i) && ($past(strobe_tgt) == TGT_UART))
        else begin $error("uart_en outside the serial port window"); err_cnt++; end

endmodule

bind dev_bridge_top dev_bridge_checker u_checker
(
    .clk          (clk),
    .core_rst_i   (core_rst),
    .dev_strobe_i (dev_strobe_i),
    .dev_addr_i   (dev_addr_i),
    .dev_ready_i  (dev_ready_o),
    .uart_en_i    (uart_en_o),
    .awvalid_i    (awvalid_o),
    .awready_i    (awready_i),
    .wvalid_i     (wvalid_o),
    .wready_i     (wready_i),
    .arvalid_i    (arvalid_o),
    .arready_i    (arready_i),
    .bready_i     (bready_o),
    .rready_i     (rready_o)
);

// File: verification/dev_bridge_tb.sv
`include "dev_bridge_settings.svh"

module dev_bridge_tb;
    import dev_bus_pkg::*;
    import axi_lite_pkg::*;

    localparam int N_WR  = 6;
    localparam int N_RD  = 6;
    localparam int N_ACC = N_WR + N_RD + 4;     // plus uart pair and two unmapped
    localparam int CLK_T = 100;

    logic      clk = 1'b0;
    logic      rst;
    logic      dev_strobe_i, dev_we_i, dev_ready_o, dev_err_o;
    dev_addr_t dev_addr_i;
    dev_be_t   dev_be_i;
    dev_data_t dev_wdata_i, dev_rdata_o;
    logic      uart_en_o, uart_we_o, uart_ready_i;
    logic [1:0] uart_addr_o;
    dev_be_t   uart_be_o;
    dev_data_t uart_wdata_o, uart_rdata_i;
    dev_addr_t awaddr_o, araddr_o;
    logic      awvalid_o, awready_i, wvalid_o, wready_i, bvalid_i, bready_o;
    logic      arvalid_o, arready_i, rvalid_i, rready_o;
    dev_data_t wdata_o, rdata_i;
    dev_be_t   wstrb_o;
    axi_resp_e bresp_i, rresp_i;

    logic [31:0] lfsr = 32'h75cb_c15d;
    int          ready_cnt = 0;     // dev_ready pulses seen
    int          acc_cnt = 0;       // accesses completed by the stimulus
    int          act_cnt = 0;       // cycles with any target activity

    // slave model state
    logic        aw_got = 1'b0, w_got = 1'b0, ar_got = 1'b0, b_drop = 1'b0, r_drop = 1'b0;
    logic        u_pend = 1'b0;
    logic [31:0] aw_wait = 0, w_wait = 0, ar_wait = 0, b_wait = 0, r_wait = 0, u_wait = 0;
    dev_addr_t   ar_addr;
    logic [1:0]  u_addr;
    dev_data_t   uart_mem [4];

    dev_bridge_top u_dev_bridge_top (.*);

    always #(CLK_T/2) clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] get_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else stop_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    // one-cycle strobe, fields stay on the bus afterwards
    task automatic start_access(input dev_addr_t addr, input logic we, input dev_be_t be,
                                input dev_data_t data);
        @(negedge clk);
        dev_strobe_i = 1'b1;
        dev_addr_i   = addr;
        dev_we_i     = we;
        dev_be_i     = be;
        dev_wdata_i  = data;
        @(negedge clk);
        dev_strobe_i = 1'b0;
    endtask

    task automatic finish_access(input string name, output dev_data_t rdata, output logic err);
        while (!dev_ready_o)
            @(negedge clk);
        rdata = dev_rdata_o;
        err   = dev_err_o;
        acc_cnt++;
        @(negedge clk);
        check_val({name, " ready count"}, acc_cnt, ready_cnt);  // one pulse per access
    endtask

    always @(posedge clk)
    begin
        if (dev_ready_o)
            ready_cnt <= ready_cnt + 1;
        if (uart_en_o || awvalid_o || wvalid_o || arvalid_o)
            act_cnt <= act_cnt + 1;
    end

    // ------------------------------------------------------------------
    // axi-lite slave and serial port models, driven on the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (b_drop)
            begin
                bvalid_i = 1'b0;
                b_drop   = 1'b0;
            end
            else if (bvalid_i && bready_o)
                b_drop = 1'b1;              // handshake on the next edge
            else if (aw_got && w_got)
            begin
                if (b_wait == 0)
                begin
                    bvalid_i = 1'b1;
                    bresp_i  = OKAY;
                    aw_got   = 1'b0;
                    w_got    = 1'b0;
                    b_wait   = get_bits(2);
                end
                else
                    b_wait = b_wait - 1;
            end
            awready_i = 1'b0;
            if (awvalid_o && !aw_got)
            begin
                if (aw_wait == 0)
                begin
                    awready_i = 1'b1;
                    aw_got    = 1'b1;
                    aw_wait   = get_bits(2);
                end
                else
                    aw_wait = aw_wait - 1;
            end
            wready_i = 1'b0;
            if (wvalid_o && !w_got)
            begin
                if (w_wait == 0)
                begin
                    wready_i = 1'b1;
                    w_got    = 1'b1;
                    w_wait   = get_bits(2);
                end
                else
                    w_wait = w_wait - 1;
            end
            // read side, slverr on address bit 4
            if (r_drop)
            begin
                rvalid_i = 1'b0;
                r_drop   = 1'b0;
            end
            else if (rvalid_i && rready_o)
                r_drop = 1'b1;
            else if (ar_got)
            begin
                if (r_wait == 0)
                begin
                    rvalid_i = 1'b1;
                    rdata_i  = ar_addr ^ 32'h5a5a_a5a5;
                    rresp_i  = ar_addr[4] ? SLVERR : OKAY;
                    ar_got   = 1'b0;
                    r_wait   = get_bits(2);
                end
                else
                    r_wait = r_wait - 1;
            end
            arready_i = 1'b0;
            if (arvalid_o && !ar_got)
            begin
                if (ar_wait == 0)
                begin
                    arready_i = 1'b1;
                    ar_got    = 1'b1;
                    ar_addr   = araddr_o;
                    ar_wait   = get_bits(2);
                end
                else
                    ar_wait = ar_wait - 1;
            end
            // serial port, answers after a random delay
            uart_ready_i = 1'b0;
            if (uart_en_o)
            begin
                u_pend = 1'b1;
                u_addr = uart_addr_o;
                u_wait = get_bits(2);
                for (int lane = 0; lane < `DEV_BE_W; lane++)
                    if (uart_we_o && uart_be_o[lane])
                        uart_mem[uart_addr_o][8*lane +: 8] = uart_wdata_o[8*lane +: 8];
            end
            else if (u_pend)
            begin
                if (u_wait == 0)
                begin
                    uart_ready_i = 1'b1;
                    uart_rdata_i = uart_mem[u_addr];
                    u_pend       = 1'b0;
                end
                else
                    u_wait = u_wait - 1;
            end
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial
    begin
        dev_addr_t   addr;
        dev_data_t   data;
        dev_data_t   rdata;
        logic [31:0] tmp;
        logic        err;
        int          act_before;
        rst = 1'b1;
        {dev_strobe_i, dev_we_i, dev_addr_i, dev_be_i, dev_wdata_i} = '0;
        {uart_ready_i, uart_rdata_i, awready_i, wready_i, bvalid_i} = '0;
        {arready_i, rvalid_i, rdata_i} = '0;
        bresp_i = OKAY;
        rresp_i = OKAY;
        for (int i = 0; i < 4; i++)
            uart_mem[i] = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // strobe held through the whole stretched reset is ignored
        dev_strobe_i = 1'b1;
        dev_addr_i   = 32'h1000_0000;
        repeat (`DEV_RST_HOLD)
        begin
            @(negedge clk);
            check_val("reset_hold ready", 32'h0, {31'b0, dev_ready_o});
        end
        dev_strobe_i = 1'b0;
        repeat (2)
        begin
            @(negedge clk);
            check_val("reset_hold ready", 32'h0, {31'b0, dev_ready_o});
        end

        // serial port write on lanes 0 and 2, then read back
        data = get_bits(32);
        start_access(32'hC000_0004, 1'b1, 4'h5, data);
        check_val("uart_write en", 32'h1, {31'b0, uart_en_o});     // cycle after the strobe
        check_val("uart_write addr", 32'h1, {30'b0, uart_addr_o}); // word 1 of the port
        check_val("uart_write be", 32'h5, {28'b0, uart_be_o});
        finish_access("uart_write", rdata, err);
        check_val("uart_write err", 32'h0, {31'b0, err});
        start_access(32'hC000_0004, 1'b0, 4'hf, 32'h0);
        finish_access("uart_read", rdata, err);
        check_val("uart_read data", data & 32'h00ff_00ff, rdata);   // other lanes stay zero
        check_val("uart_read err", 32'h0, {31'b0, err});

        // axi writes, payload seen on aw and w
        for (int i = 0; i < N_WR; i++)
        begin
            tmp  = get_bits(24);
            addr = {`DEV_SPI_BASE, tmp[23:0]};
            data = get_bits(32);
            tmp  = get_bits(4);
            start_access(addr, 1'b1, tmp[3:0], data);
            while (!awvalid_o)
                @(negedge clk);
            check_val("axi_write awaddr", addr, awaddr_o);
            check_val("axi_write wdata", data, wdata_o);
            check_val("axi_write wstrb", {28'b0, tmp[3:0]}, {28'b0, wstrb_o});
            finish_access("axi_write", rdata, err);
            check_val("axi_write err", 32'h0, {31'b0, err});
        end

        // axi reads, bit 4 alternates the error case
        for (int i = 0; i < N_RD; i++)
        begin
            tmp     = get_bits(24);
            addr    = {`DEV_SPI_BASE, tmp[23:0]};
            addr[4] = i[0];
            start_access(addr, 1'b0, 4'hf, 32'h0);
            finish_access("axi_read", rdata, err);
            check_val("axi_read data", addr ^ 32'h5a5a_a5a5, rdata);
            check_val("axi_read err", {31'b0, addr[4]}, {31'b0, err});
        end

        // unmapped, answered by the decoder alone
        act_before = act_cnt;
        start_access(32'h1000_0040, 1'b0, 4'hf, 32'h0);
        finish_access("unmapped_read", rdata, err);
        check_val("unmapped_read data", 32'h0, rdata);
        check_val("unmapped_read err", 32'h1, {31'b0, err});
        start_access(32'h10ab_cd00, 1'b1, 4'h3, 32'h1234_5678);
        finish_access("unmapped_write", rdata, err);
        check_val("unmapped_write data", 32'h0, rdata);
        check_val("unmapped_write err", 32'h1, {31'b0, err});
        check_val("unmapped activity", act_before, act_cnt);

        repeat (4) @(negedge clk);
        check_val("ready total", acc_cnt, ready_cnt);   // no stray pulse after the last access
        if (u_dev_bridge_top.u_checker.err_cnt != 0)
            stop_run("a protocol assertion in the bound checker failed");
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

    // watchdog
    initial
    begin
        #(N_ACC * 200 * CLK_T);
        stop_run("watchdog expired before all accesses completed");
    end

endmodule

// File: dev_bridge.f
+incdir+include
rtl/dev_bus_pkg.sv
rtl/axi_lite_pkg.sv
rtl/dev_req_if.sv
rtl/rst_stretch.sv
rtl/dev_decoder.sv
rtl/axi_lite_master.sv
rtl/dev_bridge_top.sv
verification/dev_bridge_checker.sv
verification/dev_bridge_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := dev_bridge_tb
FILELIST   := dev_bridge.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
